// File: src.f
+incdir+hw
hw/l2c_cmp_pkg.sv
hw/cmp_stage_reg.sv
hw/cmp_status_update.sv
hw/cmp_data_req.sv
hw/cmp_rfifo_resp.sv
hw/l2c_cmp_top.sv
tests/tb_l2c_cmp.sv

// File: tests/tb_l2c_cmp.sv
// Directed tests of the compare stage; hit vectors are one-hot and aligned with the stage cycle
`timescale 1ns/1ps
`default_nettype none

`include "l2c_cmp_params.svh"

module tb_l2c_cmp
  import l2c_cmp_pkg::*;
;

  // Whole run is under 400 cycles
  localparam int COHERENCE_ITERS = 24;
  localparam int TIMEOUT_CYCLES  = 2000;

  logic        l2c_clk = 1'b0;
  logic        cpurst_b;
  logic        ttecc_vld;
  l2_addr_t    ttecc_addr;
  sid_t        ttecc_sid;
  cmp_op_t     ttecc_op;
  way_vec_t    cmp_way_v_hit;
  way_vec_t    cmp_way_vd_hit;
  way_vec_t    cmp_way_vs_hit;
  way_vec_t    cmp_way_vu_hit;
  way_vec_t    cmp_refill_ptr;
  status_vec_t way_status_dout;
  logic        tag_ram_idle;
  logic        data_ram_idle;
  logic        cmp_data_vld;

  logic        cmp_stage_vld;
  logic        cmp_stage_stall;
  logic        cmp_req_vld;
  logic        cmp_tag_cen;
  way_vec_t    cmp_tag_wen;
  tag_index_t  cmp_tag_index;
  logic        cmp_dirty_cen;
  way_vec_t    cmp_dirty_way;
  status_t     cmp_dirty_wen;
  status_t     cmp_dirty_din;
  logic        cmp_data_req;
  logic        cmp_data_wen;
  data_index_t cmp_data_index;
  logic        cmp_rfifo_create;
  sid_t        cmp_rfifo_sid;
  resp_t       cmp_rfifo_resp;

  logic [31:0] rng_state;
  int          cycle_cnt = 0;

  l2c_cmp_top uut (
    .l2c_clk          (l2c_clk),
    .cpurst_b         (cpurst_b),
    .ttecc_vld        (ttecc_vld),
    .ttecc_addr       (ttecc_addr),
    .ttecc_sid        (ttecc_sid),
    .ttecc_op         (ttecc_op),
    .cmp_way_v_hit    (cmp_way_v_hit),
    .cmp_way_vd_hit   (cmp_way_vd_hit),
    .cmp_way_vs_hit   (cmp_way_vs_hit),
    .cmp_way_vu_hit   (cmp_way_vu_hit),
    .cmp_refill_ptr   (cmp_refill_ptr),
    .way_status_dout  (way_status_dout),
    .tag_ram_idle     (tag_ram_idle),
    .data_ram_idle    (data_ram_idle),
    .cmp_data_vld     (cmp_data_vld),
    .cmp_stage_vld    (cmp_stage_vld),
    .cmp_stage_stall  (cmp_stage_stall),
    .cmp_req_vld      (cmp_req_vld),
    .cmp_tag_cen      (cmp_tag_cen),
    .cmp_tag_wen      (cmp_tag_wen),
    .cmp_tag_index    (cmp_tag_index),
    .cmp_dirty_cen    (cmp_dirty_cen),
    .cmp_dirty_way    (cmp_dirty_way),
    .cmp_dirty_wen    (cmp_dirty_wen),
    .cmp_dirty_din    (cmp_dirty_din),
    .cmp_data_req     (cmp_data_req),
    .cmp_data_wen     (cmp_data_wen),
    .cmp_data_index   (cmp_data_index),
    .cmp_rfifo_create (cmp_rfifo_create),
    .cmp_rfifo_sid    (cmp_rfifo_sid),
    .cmp_rfifo_resp   (cmp_rfifo_resp)
  );

  // 100 ns period
  always #50 l2c_clk = ~l2c_clk;

  always @(posedge l2c_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  // ==============================
  // Helpers
  // ==============================
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      $display("Test failures found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic l2_addr_t rand_addr();
    logic [63:0] r;
    r = {next_rand(), next_rand()};
    return r[`L2C_ADDR_W-1:0];
  endfunction

  function automatic sid_t rand_sid();
    logic [31:0] r;
    r = next_rand();
    return r[`L2C_SID_W-1:0];
  endfunction

  // Response entry expected for the coherence ops
  function automatic logic create_rule(input cmp_op_t op, input logic hit,
                                       input logic dirty, input logic shared,
                                       input logic uniq, input logic tag_idle);
    case (op)
      OP_CLN:    return !hit || !dirty;
      OP_ICLN:   return !hit || (!dirty && tag_idle);
      OP_INV:    return !hit || tag_idle;
      OP_UNIQUE: return !shared || tag_idle;
      OP_SHARED: return !uniq || tag_idle;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic present_req(input cmp_op_t op, input l2_addr_t addr, input sid_t sid);
    @(posedge l2c_clk);
    ttecc_vld  <= 1'b1;
    ttecc_op   <= op;
    ttecc_addr <= addr;
    ttecc_sid  <= sid;
  endtask

  task automatic drive_lookup(input way_vec_t v, input way_vec_t vd, input way_vec_t vs,
                              input way_vec_t vu, input way_vec_t refill,
                              input status_vec_t status);
    cmp_way_v_hit   <= v;
    cmp_way_vd_hit  <= vd;
    cmp_way_vs_hit  <= vs;
    cmp_way_vu_hit  <= vu;
    cmp_refill_ptr  <= refill;
    way_status_dout <= status;
  endtask

  // Returns at the edge that accepted the request
  task automatic wait_accept();
    logic accepted;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(negedge l2c_clk);
      accepted = !cmp_stage_stall;
      @(posedge l2c_clk);
    end
  endtask

  // Lookup results follow the request into the stage
  task automatic issue_req(input cmp_op_t op, input l2_addr_t addr, input sid_t sid,
                           input way_vec_t v, input way_vec_t vd, input way_vec_t vs,
                           input way_vec_t vu, input way_vec_t refill,
                           input status_vec_t status);
    present_req(op, addr, sid);
    wait_accept();
    ttecc_vld <= 1'b0;
    drive_lookup(v, vd, vs, vu, refill, status);
  endtask

  task automatic expect_idle_outputs();
    check_value("cmp_stage_vld", cmp_stage_vld, 0);
    check_value("cmp_stage_stall", cmp_stage_stall, 0);
    check_value("cmp_data_req", cmp_data_req, 0);
    check_value("cmp_tag_cen", cmp_tag_cen, 0);
    check_value("cmp_dirty_cen", cmp_dirty_cen, 0);
    check_value("cmp_rfifo_create", cmp_rfifo_create, 0);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic reset_check();
    repeat (16)
    begin
      @(negedge l2c_clk);
      expect_idle_outputs();
    end
    @(posedge l2c_clk);
    cpurst_b <= 1'b1;
    repeat (3)
    begin
      @(negedge l2c_clk);
      expect_idle_outputs();
    end
  endtask

  task automatic read_hit_miss();
    way_idx_t k;
    way_vec_t v;
    l2_addr_t addr;
    sid_t     sid;
    k = way_idx_t'(next_rand() % `L2C_WAYS);
    v = '0;
    v[k] = 1'b1;
    addr = rand_addr();
    sid = rand_sid();
    issue_req(OP_READ, addr, sid, v, '0, v, '0, '0, {next_rand(), next_rand()});
    @(negedge l2c_clk);
    check_value("cmp_stage_vld", cmp_stage_vld, 1);
    check_value("cmp_stage_stall", cmp_stage_stall, 0);
    check_value("cmp_data_req", cmp_data_req, 1);
    check_value("cmp_data_wen", cmp_data_wen, 0);
    check_value("cmp_data_index", cmp_data_index, {k, addr[`L2C_TAG_INDEX_W-1:0]});
    check_value("cmp_rfifo_create", cmp_rfifo_create, 0);

    // Miss answers straight from the stage
    addr = rand_addr();
    sid = rand_sid();
    issue_req(OP_READ, addr, sid, '0, '0, '0, '0, '0, {next_rand(), next_rand()});
    @(negedge l2c_clk);
    check_value("cmp_data_req", cmp_data_req, 0);
    check_value("cmp_tag_cen", cmp_tag_cen, 0);
    check_value("cmp_dirty_cen", cmp_dirty_cen, 0);
    check_value("cmp_rfifo_create", cmp_rfifo_create, 1);
    check_value("cmp_rfifo_resp", cmp_rfifo_resp, 0);
    check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid);
  endtask

  task automatic write_refill();
    int       i;
    cmp_op_t  op;
    status_t  din_exp;
    way_idx_t k;
    way_vec_t ptr;
    l2_addr_t addr;
    sid_t     sid;
    @(posedge l2c_clk);
    cmp_data_vld <= 1'b1;
    for (i = 0; i < 4; i++)
    begin
      // Fresh line is valid, shared for SD/SC, dirty for SD/UD
      case (i)
        0:
        begin
          op = OP_WRITE_SD;
          din_exp = 4'b1110;
        end
        1:
        begin
          op = OP_WRITE_SC;
          din_exp = 4'b1100;
        end
        2:
        begin
          op = OP_WRITE_UC;
          din_exp = 4'b1000;
        end
        default:
        begin
          op = OP_WRITE_UD;
          din_exp = 4'b1010;
        end
      endcase
      k = way_idx_t'(next_rand() % `L2C_WAYS);
      ptr = '0;
      ptr[k] = 1'b1;
      addr = rand_addr();
      sid = rand_sid();
      issue_req(op, addr, sid, '0, '0, '0, '0, ptr, {next_rand(), next_rand()});
      @(negedge l2c_clk);
      check_value("cmp_stage_stall", cmp_stage_stall, 0);
      check_value("cmp_tag_cen", cmp_tag_cen, 1);
      check_value("cmp_tag_wen", cmp_tag_wen, ptr);
      check_value("cmp_tag_index", cmp_tag_index, addr[`L2C_TAG_INDEX_W-1:0]);
      check_value("cmp_dirty_cen", cmp_dirty_cen, 1);
      check_value("cmp_dirty_way", cmp_dirty_way, ptr);
      check_value("cmp_dirty_wen", cmp_dirty_wen, 4'hf);
      check_value("cmp_dirty_din", cmp_dirty_din, din_exp);
      check_value("cmp_data_req", cmp_data_req, 1);
      check_value("cmp_data_wen", cmp_data_wen, 1);
      check_value("cmp_data_index", cmp_data_index, {k, addr[`L2C_TAG_INDEX_W-1:0]});
      check_value("cmp_rfifo_create", cmp_rfifo_create, 1);
      check_value("cmp_rfifo_resp", cmp_rfifo_resp, 0);
      check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid);
    end
    @(posedge l2c_clk);
    cmp_data_vld <= 1'b0;
  endtask

  task automatic data_backpressure();
    way_idx_t k;
    way_vec_t v;
    l2_addr_t addr_a;
    l2_addr_t addr_b;
    sid_t     sid_a;
    sid_t     sid_b;
    k = way_idx_t'(next_rand() % `L2C_WAYS);
    v = '0;
    v[k] = 1'b1;
    addr_a = rand_addr();
    addr_b = rand_addr();
    sid_a = rand_sid();
    sid_b = sid_a + 1'b1;
    @(posedge l2c_clk);
    data_ram_idle <= 1'b0;
    issue_req(OP_READ, addr_a, sid_a, v, '0, v, '0, '0, {next_rand(), next_rand()});
    @(negedge l2c_clk);
    check_value("cmp_stage_stall", cmp_stage_stall, 1);

    // Second request waits behind the stall
    present_req(OP_READ, addr_b, sid_b);
    repeat (4)
    begin
      @(negedge l2c_clk);
      check_value("cmp_stage_vld", cmp_stage_vld, 1);
      check_value("cmp_stage_stall", cmp_stage_stall, 1);
      check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid_a);
      check_value("cmp_rfifo_create", cmp_rfifo_create, 0);
      @(posedge l2c_clk);
    end
    data_ram_idle <= 1'b1;
    @(negedge l2c_clk);
    check_value("cmp_data_req", cmp_data_req, 1);
    check_value("cmp_data_index", cmp_data_index, {k, addr_a[`L2C_TAG_INDEX_W-1:0]});
    check_value("cmp_stage_stall", cmp_stage_stall, 0);
    check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid_a);

    // Waiting read miss goes in at this edge
    @(posedge l2c_clk);
    ttecc_vld <= 1'b0;
    drive_lookup('0, '0, '0, '0, '0, {next_rand(), next_rand()});
    @(negedge l2c_clk);
    check_value("cmp_stage_vld", cmp_stage_vld, 1);
    check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid_b);
    check_value("cmp_data_req", cmp_data_req, 0);
    check_value("cmp_rfifo_create", cmp_rfifo_create, 1);
    check_value("cmp_rfifo_resp", cmp_rfifo_resp, 0);
  endtask

  task automatic coherence_ops(input logic tag_idle);
    int          n;
    logic [31:0] r;
    cmp_op_t     op;
    logic        hit;
    logic        dirty;
    logic        shared;
    logic        uniq;
    way_idx_t    k;
    way_vec_t    v;
    status_vec_t st;
    status_t     old;
    status_t     set_b;
    status_t     clr_b;
    status_t     din_exp;
    status_t     wen_exp;
    logic        upd;
    logic        data_rd;
    logic        stall_exp;
    sid_t        sid;
    @(posedge l2c_clk);
    tag_ram_idle <= tag_idle;
    for (n = 0; n < COHERENCE_ITERS; n++)
    begin
      r = next_rand();
      case (r % 5)
        0:       op = OP_CLN;
        1:       op = OP_ICLN;
        2:       op = OP_INV;
        3:       op = OP_UNIQUE;
        default: op = OP_SHARED;
      endcase
      hit = r[8];
      dirty = hit & r[9];
      shared = hit & r[10];
      uniq = hit & ~r[10];
      k = r[15:12];
      v = '0;
      v[k] = hit;
      st = {next_rand(), next_rand()};
      old = hit ? st[int'(k)*`L2C_STATUS_W +: `L2C_STATUS_W] : '0;

      set_b = '0;
      clr_b = '0;
      case (op)
        OP_CLN:
          if (dirty)
            clr_b = 4'b0010;
        // Hit line is dropped: valid, shared and dirty go
        OP_ICLN, OP_INV:
          if (hit)
            clr_b = 4'b1110;
        OP_UNIQUE:
          if (shared)
            clr_b = 4'b0100;
        OP_SHARED:
          if (uniq)
            set_b = 4'b0100;
        default:
          set_b = '0;
      endcase
      din_exp = (old | set_b) & ~clr_b;
      wen_exp = set_b | clr_b;
      upd = |wen_exp;
      data_rd = ((op == OP_CLN) || (op == OP_ICLN)) && dirty;
      stall_exp = upd && !tag_idle;

      sid = rand_sid();
      issue_req(op, rand_addr(), sid, v, dirty ? v : '0, shared ? v : '0,
                uniq ? v : '0, way_vec_t'(next_rand()), st);
      @(negedge l2c_clk);
      check_value("cmp_stage_vld", cmp_stage_vld, 1);
      check_value("cmp_req_vld", cmp_req_vld, upd);
      check_value("cmp_stage_stall", cmp_stage_stall, stall_exp);
      check_value("cmp_tag_cen", cmp_tag_cen, 0);
      check_value("cmp_dirty_cen", cmp_dirty_cen, upd);
      check_value("cmp_dirty_way", cmp_dirty_way, v);
      check_value("cmp_dirty_wen", cmp_dirty_wen, wen_exp);
      check_value("cmp_dirty_din", cmp_dirty_din, din_exp);
      check_value("cmp_data_req", cmp_data_req, data_rd);
      check_value("cmp_rfifo_create", cmp_rfifo_create,
                  !stall_exp && create_rule(op, hit, dirty, shared, uniq, tag_idle));
      check_value("cmp_rfifo_resp", cmp_rfifo_resp, {hit, shared, dirty});
      check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid);

      // Tag RAM frees up and the held request completes
      if (stall_exp)
      begin
        @(posedge l2c_clk);
        tag_ram_idle <= 1'b1;
        @(negedge l2c_clk);
        check_value("cmp_stage_stall", cmp_stage_stall, 0);
        check_value("cmp_data_req", cmp_data_req, 0);
        check_value("cmp_dirty_cen", cmp_dirty_cen, upd);
        check_value("cmp_rfifo_create", cmp_rfifo_create,
                    create_rule(op, hit, dirty, shared, uniq, 1'b1));
        check_value("cmp_rfifo_sid", cmp_rfifo_sid, sid);
        @(posedge l2c_clk);
        tag_ram_idle <= tag_idle;
      end
    end
    @(posedge l2c_clk);
    tag_ram_idle <= 1'b1;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    rng_state       = 32'd96304;
    cpurst_b        = 1'b0;
    ttecc_vld       = 1'b0;
    ttecc_addr      = '0;
    ttecc_sid       = '0;
    ttecc_op        = OP_NOP;
    cmp_way_v_hit   = '0;
    cmp_way_vd_hit  = '0;
    cmp_way_vs_hit  = '0;
    cmp_way_vu_hit  = '0;
    cmp_refill_ptr  = '0;
    way_status_dout = '0;
    tag_ram_idle    = 1'b1;
    data_ram_idle   = 1'b1;
    cmp_data_vld    = 1'b0;

    reset_check();
    read_hit_miss();
    write_refill();
    data_backpressure();
    coherence_ops(1'b1);
    coherence_ops(1'b0);

    repeat (2) @(posedge l2c_clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/l2c_cmp_top.sv
// Compare stage top, hit vectors and status words come from the lookup one stage earlier
`timescale 1ns/1ps
`default_nettype none

module l2c_cmp_top
  import l2c_cmp_pkg::*;
(
  input  wire              l2c_clk,
  input  wire              cpurst_b,
  // Upstream request
  input  wire              ttecc_vld,
  input  wire l2_addr_t    ttecc_addr,
  input  wire sid_t        ttecc_sid,
  input  wire cmp_op_t     ttecc_op,
  // Lookup results aligned with the stage
  input  wire way_vec_t    cmp_way_v_hit,
  input  wire way_vec_t    cmp_way_vd_hit,
  input  wire way_vec_t    cmp_way_vs_hit,
  input  wire way_vec_t    cmp_way_vu_hit,
  input  wire way_vec_t    cmp_refill_ptr,
  input  wire status_vec_t way_status_dout,
  // RAM and write buffer state
  input  wire              tag_ram_idle,
  input  wire              data_ram_idle,
  input  wire              cmp_data_vld,
  // Stage state
  output wire              cmp_stage_vld,
  output wire              cmp_stage_stall,
  output wire              cmp_req_vld,
  // Tag and status RAM
  output wire              cmp_tag_cen,
  output wire way_vec_t    cmp_tag_wen,
  output wire tag_index_t  cmp_tag_index,
  output wire              cmp_dirty_cen,
  output wire way_vec_t    cmp_dirty_way,
  output wire status_t     cmp_dirty_wen,
  output wire status_t     cmp_dirty_din,
  // Data RAM
  output wire              cmp_data_req,
  output wire              cmp_data_wen,
  output wire data_index_t cmp_data_index,
  // Response FIFO
  output wire              cmp_rfifo_create,
  output wire sid_t        cmp_rfifo_sid,
  output wire resp_t       cmp_rfifo_resp
);

  wire           cmp_stage_load;
  wire l2_addr_t cmp_stage_addr;
  wire sid_t     cmp_stage_sid;
  wire cmp_op_t  cmp_stage_op;
  wire           cmp_stall_by_data;
  wire           cmp_cache_hit;
  wire           cmp_hit_dirty;
  wire           cmp_hit_shared;
  wire           cmp_hit_unique;
  wire way_vec_t cmp_way_ptr;

  // ============================
  // Stage register
  // ============================
  cmp_stage_reg u_stage (
    .l2c_clk           (l2c_clk),
    .cpurst_b          (cpurst_b),
    .ttecc_vld         (ttecc_vld),
    .ttecc_addr        (ttecc_addr),
    .ttecc_sid         (ttecc_sid),
    .ttecc_op          (ttecc_op),
    .cmp_stall_by_data (cmp_stall_by_data),
    .cmp_req_vld       (cmp_req_vld),
    .tag_ram_idle      (tag_ram_idle),
    .cmp_stage_vld     (cmp_stage_vld),
    .cmp_stage_stall   (cmp_stage_stall),
    .cmp_stage_load    (cmp_stage_load),
    .cmp_stage_addr    (cmp_stage_addr),
    .cmp_stage_sid     (cmp_stage_sid),
    .cmp_stage_op      (cmp_stage_op)
  );

  // ============================
  // Decode units
  // ============================
  cmp_status_update u_status (
    .cmp_stage_vld     (cmp_stage_vld),
    .cmp_stage_op      (cmp_stage_op),
    .cmp_stage_addr    (cmp_stage_addr),
    .cmp_way_v_hit     (cmp_way_v_hit),
    .cmp_way_vd_hit    (cmp_way_vd_hit),
    .cmp_way_vs_hit    (cmp_way_vs_hit),
    .cmp_way_vu_hit    (cmp_way_vu_hit),
    .cmp_refill_ptr    (cmp_refill_ptr),
    .way_status_dout   (way_status_dout),
    .cmp_stall_by_data (cmp_stall_by_data),
    .cmp_cache_hit     (cmp_cache_hit),
    .cmp_hit_dirty     (cmp_hit_dirty),
    .cmp_hit_shared    (cmp_hit_shared),
    .cmp_hit_unique    (cmp_hit_unique),
    .cmp_way_ptr       (cmp_way_ptr),
    .cmp_req_vld       (cmp_req_vld),
    .cmp_tag_cen       (cmp_tag_cen),
    .cmp_tag_wen       (cmp_tag_wen),
    .cmp_tag_index     (cmp_tag_index),
    .cmp_dirty_cen     (cmp_dirty_cen),
    .cmp_dirty_way     (cmp_dirty_way),
    .cmp_dirty_wen     (cmp_dirty_wen),
    .cmp_dirty_din     (cmp_dirty_din)
  );

  cmp_data_req u_data (
    .l2c_clk           (l2c_clk),
    .cpurst_b          (cpurst_b),
    .cmp_stage_vld     (cmp_stage_vld),
    .cmp_stage_load    (cmp_stage_load),
    .cmp_stage_op      (cmp_stage_op),
    .cmp_stage_addr    (cmp_stage_addr),
    .cmp_cache_hit     (cmp_cache_hit),
    .cmp_hit_dirty     (cmp_hit_dirty),
    .cmp_way_ptr       (cmp_way_ptr),
    .cmp_data_vld      (cmp_data_vld),
    .data_ram_idle     (data_ram_idle),
    .cmp_data_req      (cmp_data_req),
    .cmp_data_wen      (cmp_data_wen),
    .cmp_data_index    (cmp_data_index),
    .cmp_stall_by_data (cmp_stall_by_data)
  );

  cmp_rfifo_resp u_rfifo (
    .cmp_stage_vld     (cmp_stage_vld),
    .cmp_stage_stall   (cmp_stage_stall),
    .cmp_stage_op      (cmp_stage_op),
    .cmp_stage_sid     (cmp_stage_sid),
    .cmp_cache_hit     (cmp_cache_hit),
    .cmp_hit_dirty     (cmp_hit_dirty),
    .cmp_hit_shared    (cmp_hit_shared),
    .cmp_hit_unique    (cmp_hit_unique),
    .cmp_stall_by_data (cmp_stall_by_data),
    .cmp_data_vld      (cmp_data_vld),
    .tag_ram_idle      (tag_ram_idle),
    .cmp_rfifo_create  (cmp_rfifo_create),
    .cmp_rfifo_sid     (cmp_rfifo_sid),
    .cmp_rfifo_resp    (cmp_rfifo_resp)
  );

endmodule

`default_nettype wire

// File: hw/cmp_rfifo_resp.sv
// Creates at most one response entry per request, in its last stage cycle
`timescale 1ns/1ps
`default_nettype none

module cmp_rfifo_resp
  import l2c_cmp_pkg::*;
(
  input  wire          cmp_stage_vld,
  input  wire          cmp_stage_stall,
  input  wire cmp_op_t cmp_stage_op,
  input  wire sid_t    cmp_stage_sid,
  input  wire          cmp_cache_hit,
  input  wire          cmp_hit_dirty,
  input  wire          cmp_hit_shared,
  input  wire          cmp_hit_unique,
  input  wire          cmp_stall_by_data,
  input  wire          cmp_data_vld,
  input  wire          tag_ram_idle,
  output logic         cmp_rfifo_create,
  output sid_t         cmp_rfifo_sid,
  output resp_t        cmp_rfifo_resp
);

  logic op_create;

  // ============================
  // Create conditions per op
  // ============================
  // Read hits and dirty cleans answer from the data path instead
  always_comb
  begin
    case (cmp_stage_op)
      OP_READ:
        op_create = ~cmp_cache_hit;
      OP_WRITE_SD, OP_WRITE_SC, OP_WRITE_UC, OP_WRITE_UD:
        op_create = cmp_data_vld & tag_ram_idle & ~cmp_stall_by_data;
      OP_CLN:
        op_create = ~cmp_cache_hit | ~cmp_hit_dirty;
      OP_ICLN:
        op_create = ~cmp_cache_hit | (~cmp_hit_dirty & tag_ram_idle);
      OP_INV:
        op_create = ~cmp_cache_hit | tag_ram_idle;
      OP_UNIQUE:
        op_create = ~cmp_hit_shared | tag_ram_idle;
      OP_SHARED:
        op_create = ~cmp_hit_unique | tag_ram_idle;
      default:
        op_create = 1'b0;
    endcase
  end

  assign cmp_rfifo_create = cmp_stage_vld & ~cmp_stage_stall & op_create;

  // ============================
  // Entry payload
  // ============================
  assign cmp_rfifo_sid  = cmp_stage_sid;
  assign cmp_rfifo_resp = {cmp_cache_hit, cmp_hit_shared, cmp_hit_dirty};

endmodule

`default_nettype wire

// File: hw/cmp_data_req.sv
// One data RAM access per stage occupancy; the way pointer must be one-hot when it is used
`timescale 1ns/1ps
`default_nettype none

`include "l2c_cmp_params.svh"

module cmp_data_req
  import l2c_cmp_pkg::*;
(
  input  wire           l2c_clk,
  input  wire           cpurst_b,
  input  wire           cmp_stage_vld,
  input  wire           cmp_stage_load,
  input  wire cmp_op_t  cmp_stage_op,
  input  wire l2_addr_t cmp_stage_addr,
  input  wire           cmp_cache_hit,
  input  wire           cmp_hit_dirty,
  input  wire way_vec_t cmp_way_ptr,
  input  wire           cmp_data_vld,
  input  wire           data_ram_idle,
  output logic          cmp_data_req,
  output logic          cmp_data_wen,
  output data_index_t   cmp_data_index,
  output logic          cmp_stall_by_data
);

  logic     op_write;
  logic     data_rd;
  logic     data_wr;
  logic     data_issued;
  logic     stall_rd;
  logic     stall_wr;
  way_idx_t data_way;

  assign op_write = op_is_write(cmp_stage_op);

  // ============================
  // Data RAM request
  // ============================
  // Read hit, or a clean that must write back a dirty line
  assign data_rd = ((cmp_stage_op == OP_READ) & cmp_cache_hit) |
                   (((cmp_stage_op == OP_CLN) | (cmp_stage_op == OP_ICLN)) & cmp_hit_dirty);
  assign data_wr = op_write & cmp_data_vld;

  assign cmp_data_req = cmp_stage_vld & (data_rd | data_wr) & ~data_issued;
  assign cmp_data_wen = data_wr;

  // Set once the RAM took the request, cleared by the next request
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      data_issued <= 1'b0;
    else if (cmp_stage_load)
      data_issued <= 1'b0;
    else if (cmp_data_req & data_ram_idle)
      data_issued <= 1'b1;
  end

  // ============================
  // Data index
  // ============================
  always_comb
  begin
    data_way = '0;
    for (int i = 0; i < `L2C_WAYS; i++)
    begin
      if (cmp_way_ptr[i])
        data_way = way_idx_t'(i);
    end
  end

  assign cmp_data_index = {data_way, cmp_stage_addr[`L2C_TAG_INDEX_W-1:0]};

  // ============================
  // Data back-pressure
  // ============================
  assign stall_rd = data_rd & ~data_ram_idle;
  // Writes also wait for the write data
  assign stall_wr = op_write & (~cmp_data_vld | ~data_ram_idle);

  assign cmp_stall_by_data = cmp_stage_vld & ~data_issued & (stall_rd | stall_wr);

  a_way_ptr_onehot: assert property (@(posedge l2c_clk) disable iff (!cpurst_b)
    cmp_data_req |-> $onehot0(cmp_way_ptr))
    else $error("data request with more than one way selected");

endmodule

`default_nettype wire

// File: hw/cmp_status_update.sv
// Hit vectors and status words must be aligned with the stage; at most one way hits
`timescale 1ns/1ps
`default_nettype none

`include "l2c_cmp_params.svh"

module cmp_status_update
  import l2c_cmp_pkg::*;
(
  input  wire              cmp_stage_vld,
  input  wire cmp_op_t     cmp_stage_op,
  input  wire l2_addr_t    cmp_stage_addr,
  input  wire way_vec_t    cmp_way_v_hit,
  input  wire way_vec_t    cmp_way_vd_hit,
  input  wire way_vec_t    cmp_way_vs_hit,
  input  wire way_vec_t    cmp_way_vu_hit,
  input  wire way_vec_t    cmp_refill_ptr,
  input  wire status_vec_t way_status_dout,
  input  wire              cmp_stall_by_data,
  output logic             cmp_cache_hit,
  output logic             cmp_hit_dirty,
  output logic             cmp_hit_shared,
  output logic             cmp_hit_unique,
  output way_vec_t         cmp_way_ptr,
  output logic             cmp_req_vld,
  output logic             cmp_tag_cen,
  output way_vec_t         cmp_tag_wen,
  output tag_index_t       cmp_tag_index,
  output logic             cmp_dirty_cen,
  output way_vec_t         cmp_dirty_way,
  output status_t          cmp_dirty_wen,
  output status_t          cmp_dirty_din
);

  logic    op_write;
  logic    op_cln_any;
  logic    refill;
  logic    valid_clr;
  logic    dirty_set;
  logic    dirty_clr;
  logic    shared_set;
  logic    shared_clr;
  logic    pend_clr;
  logic    status_updt;
  status_t old_status;
  status_t set_bits;
  status_t clr_bits;

  // ============================
  // Hit reduction
  // ============================
  assign cmp_cache_hit  = |cmp_way_v_hit;
  assign cmp_hit_dirty  = |cmp_way_vd_hit;
  assign cmp_hit_shared = |cmp_way_vs_hit;
  assign cmp_hit_unique = |cmp_way_vu_hit;

  assign op_write   = op_is_write(cmp_stage_op);
  assign op_cln_any = (cmp_stage_op == OP_CLN) | (cmp_stage_op == OP_ICLN);

  // Write miss fills the victim way
  assign refill = op_write & ~cmp_cache_hit;

  // Refill way, otherwise the hit way
  assign cmp_way_ptr = refill ? cmp_refill_ptr : cmp_way_v_hit;

  // ============================
  // Status set and clear rules
  // ============================
  assign valid_clr  = ((cmp_stage_op == OP_INV) | (cmp_stage_op == OP_ICLN)) & cmp_cache_hit;

  assign dirty_set  = (cmp_stage_op == OP_WRITE_UD) | (cmp_stage_op == OP_WRITE_SD);
  assign dirty_clr  = (cmp_stage_op == OP_WRITE_UC) | (cmp_stage_op == OP_WRITE_SC) |
                      valid_clr | (op_cln_any & cmp_hit_dirty);

  // Downgrade of a unique line makes it shared
  assign shared_set = (cmp_stage_op == OP_WRITE_SD) | (cmp_stage_op == OP_WRITE_SC) |
                      ((cmp_stage_op == OP_SHARED) & cmp_hit_unique);
  assign shared_clr = (cmp_stage_op == OP_WRITE_UC) | (cmp_stage_op == OP_WRITE_UD) |
                      valid_clr | ((cmp_stage_op == OP_UNIQUE) & cmp_hit_shared);

  assign pend_clr   = refill;

  assign status_updt = op_write | valid_clr | (op_cln_any & cmp_hit_dirty) |
                       ((cmp_stage_op == OP_SHARED) & cmp_hit_unique) |
                       ((cmp_stage_op == OP_UNIQUE) & cmp_hit_shared);

  // ============================
  // Status merge
  // ============================
  // AND-OR mux of the selected way's old status
  always_comb
  begin
    old_status = '0;
    for (int i = 0; i < `L2C_WAYS; i++)
    begin
      if (cmp_way_ptr[i])
        old_status = old_status | way_status_dout[i*`L2C_STATUS_W +: `L2C_STATUS_W];
    end
  end

  assign set_bits = {refill, shared_set, dirty_set, 1'b0};
  assign clr_bits = {valid_clr, shared_clr, dirty_clr, pend_clr};

  // Refill writes a fresh word, everything else is read-modify-write
  assign cmp_dirty_din = refill ? set_bits : ((old_status | set_bits) & ~clr_bits);
  assign cmp_dirty_wen = refill ? '1 : (set_bits | clr_bits);

  // ============================
  // Tag and status RAM requests
  // ============================
  assign cmp_req_vld   = cmp_stage_vld & (refill | status_updt);

  // Hold off until the data side can go in the same cycle
  assign cmp_tag_cen   = cmp_stage_vld & refill & ~cmp_stall_by_data;
  assign cmp_dirty_cen = cmp_stage_vld & status_updt & ~cmp_stall_by_data;

  assign cmp_tag_wen   = cmp_refill_ptr & {`L2C_WAYS{refill}};
  assign cmp_dirty_way = cmp_way_ptr;
  assign cmp_tag_index = cmp_stage_addr[`L2C_TAG_INDEX_W-1:0];

endmodule

`default_nettype wire

// File: hw/cmp_stage_reg.sv
// One request slot, held while the RAMs push back; upstream must hold ttecc_vld until accepted
`timescale 1ns/1ps
`default_nettype none

module cmp_stage_reg
  import l2c_cmp_pkg::*;
(
  input  wire           l2c_clk,
  input  wire           cpurst_b,
  input  wire           ttecc_vld,
  input  wire l2_addr_t ttecc_addr,
  input  wire sid_t     ttecc_sid,
  input  wire cmp_op_t  ttecc_op,
  input  wire           cmp_stall_by_data,
  input  wire           cmp_req_vld,
  input  wire           tag_ram_idle,
  output logic          cmp_stage_vld,
  output logic          cmp_stage_stall,
  output logic          cmp_stage_load,
  output l2_addr_t      cmp_stage_addr,
  output sid_t          cmp_stage_sid,
  output cmp_op_t       cmp_stage_op
);

  // ============================
  // Stall and acceptance
  // ============================
  // Tag and status may only be written together with the data access
  assign cmp_stage_stall = cmp_stage_vld &
                           (cmp_stall_by_data | (cmp_req_vld & ~tag_ram_idle));

  assign cmp_stage_load  = ttecc_vld & ~cmp_stage_stall;

  // ============================
  // Stage registers
  // ============================
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmp_stage_vld <= 1'b0;
    else if (!cmp_stage_stall)
      cmp_stage_vld <= ttecc_vld;
  end

  // Payload only moves on acceptance
  always_ff @(posedge l2c_clk)
  begin
    if (cmp_stage_load)
    begin
      cmp_stage_addr <= ttecc_addr;
      cmp_stage_sid  <= ttecc_sid;
      cmp_stage_op   <= ttecc_op;
    end
  end

  // A refused request is presented again unchanged
  a_req_held: assert property (@(posedge l2c_clk) disable iff (!cpurst_b)
    ttecc_vld && !cmp_stage_load |=> ttecc_vld && $stable(ttecc_addr) &&
                                     $stable(ttecc_sid) && $stable(ttecc_op))
    else $error("request dropped or changed before acceptance");

endmodule

`default_nettype wire

// File: hw/l2c_cmp_pkg.sv
// Types of the compare stage, the params header must be on the include path
`default_nettype none

`include "l2c_cmp_params.svh"

package l2c_cmp_pkg;

  typedef logic [`L2C_WAYS-1:0]                 way_vec_t;
  typedef logic [`L2C_WAY_IDX_W-1:0]            way_idx_t;
  typedef logic [`L2C_ADDR_W-1:0]               l2_addr_t;
  typedef logic [`L2C_TAG_INDEX_W-1:0]          tag_index_t;
  typedef logic [`L2C_DATA_INDEX_W-1:0]         data_index_t;
  typedef logic [`L2C_SID_W-1:0]                sid_t;
  // Bit 3 valid, bit 2 shared, bit 1 dirty, bit 0 pend
  typedef logic [`L2C_STATUS_W-1:0]             status_t;
  // Way n sits in bits 4n+3..4n
  typedef logic [`L2C_WAYS*`L2C_STATUS_W-1:0]   status_vec_t;
  // Hit, shared, dirty
  typedef logic [2:0]                           resp_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_READ,
    OP_WRITE_SD,
    OP_WRITE_SC,
    OP_WRITE_UC,
    OP_WRITE_UD,
    OP_CLN,
    OP_ICLN,
    OP_INV,
    OP_UNIQUE,
    OP_SHARED
  } cmp_op_t;

  // Any of the four write kinds
  function automatic logic op_is_write(cmp_op_t op);
    return op inside {OP_WRITE_SD, OP_WRITE_SC, OP_WRITE_UC, OP_WRITE_UD};
  endfunction

endpackage

`default_nettype wire

// File: hw/l2c_cmp_params.svh
// Fixed for a 16-way cache with 512 sets and a 33-bit line address
`ifndef L2C_CMP_PARAMS_SVH
`define L2C_CMP_PARAMS_SVH

// ============================
// Cache geometry
// ============================
`define L2C_WAYS          16
`define L2C_WAY_IDX_W     4
`define L2C_ADDR_W        33

// Tag and status RAM index from the low address bits
`define L2C_TAG_INDEX_W   9

// Data RAM index is way number over the tag index
`define L2C_DATA_INDEX_W  13

// ============================
// Request and status fields
// ============================
`define L2C_SID_W         5

// Valid, shared, dirty, pend
`define L2C_STATUS_W      4

`endif
